//--- design/apb_iob_pkg.sv
package apb_iob_pkg;

   // Bus widths
   localparam int ADDR_W = 16;             // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;     // One strobe per byte

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   // Address map
   localparam int SPLIT_BIT = 12;          // Target select bit, set for registers

   // Control register bank
   localparam int    REG_IDX_W    = 2;     // Word index from addr[3:2]
   localparam int    REG_ID_IDX   = 3;     // Read-only identification word
   localparam data_t REG_ID_VALUE = 32'hA10B_0C31;

   // APB requester to target
   typedef struct packed {
      logic  sel;
      logic  enable;
      logic  write;
      addr_t addr;
      data_t wdata;
      strb_t strb;
   } apb_req_t;

   typedef struct packed {
      logic  ready;
      data_t rdata;
   } apb_rsp_t;

   // IOb request, a zero wstrb marks a read
   typedef struct packed {
      logic  avalid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   typedef struct packed {
      data_t rdata;
      logic  rvalid_nxt;                   // Read data follows next cycle
      logic  ready_nxt;                    // Accepted at the next edge
   } iob_rsp_t;

endpackage

//--- design/apb2iob.sv
`timescale 1ns/1ps

module apb2iob (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb_req_i,   // From the APB requester
   output apb_iob_pkg::apb_rsp_t apb_rsp_o,
   output apb_iob_pkg::iob_req_t iob_req_o,   // To the IOb targets
   input  apb_iob_pkg::iob_rsp_t iob_rsp_i
);

   logic phase_q;    // Set while the transfer is with the target
   logic phase_d;
   logic ready_q;    // Registered APB ready
   logic ready_d;
   logic ack_nxt;    // Target done in the next cycle

   // Writes finish on ready, reads once data is on its way
   assign ack_nxt = apb_req_i.write ? iob_rsp_i.ready_nxt : iob_rsp_i.rvalid_nxt;

   always_comb begin
      phase_d = phase_q;
      ready_d = 1'b0;
      case (phase_q)
         1'b0: begin
            if (apb_req_i.sel) begin             // Setup cycle seen
               phase_d = 1'b1;
            end
         end
         default: begin
            if (!apb_req_i.enable || ready_q) begin
               phase_d = 1'b0;                   // Access done or abandoned
            end else begin
               ready_d = ack_nxt;                // Still waiting on target
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q <= 1'b0;
         ready_q <= 1'b0;
      end else begin
         phase_q <= phase_d;
         ready_q <= ready_d;
      end
   end

   // Request follows the phase, fields pass straight through
   always_comb begin
      iob_req_o.avalid = phase_q;
      iob_req_o.addr   = apb_req_i.addr;
      iob_req_o.wdata  = apb_req_i.wdata;
      iob_req_o.wstrb  = apb_req_i.write ? apb_req_i.strb : '0;   // Reads carry no strobes
   end

   always_comb begin
      apb_rsp_o.ready = ready_q;
      apb_rsp_o.rdata = iob_rsp_i.rdata;                     // Target output is registered
   end

   // A request to a target only exists inside a selected APB transfer
   a_avalid_in_sel: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      iob_req_o.avalid |-> apb_req_i.sel
   ) else $error("apb2iob: avalid high without sel");

   // Ready answers an access phase
   a_ready_in_enable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_rsp_o.ready |-> apb_req_i.enable
   ) else $error("apb2iob: ready high outside the access phase");

endmodule

//--- design/iob_split.sv
`timescale 1ns/1ps

module iob_split (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t req_i,       // From the bridge
   output apb_iob_pkg::iob_rsp_t rsp_o,
   output apb_iob_pkg::iob_req_t ram_req_o,   // Low half of the map
   input  apb_iob_pkg::iob_rsp_t ram_rsp_i,
   output apb_iob_pkg::iob_req_t reg_req_o,   // High half of the map
   input  apb_iob_pkg::iob_rsp_t reg_rsp_i
);

   // Offset bits below the select bit
   localparam apb_iob_pkg::addr_t OFFS_MASK =
      apb_iob_pkg::addr_t'((1 << apb_iob_pkg::SPLIT_BIT) - 1);

   logic hit_reg;      // Current request targets the registers
   logic sel_reg_q;    // Choice for the data coming back

   assign hit_reg = req_i.addr[apb_iob_pkg::SPLIT_BIT];

   always_comb begin
      ram_req_o        = req_i;
      reg_req_o        = req_i;
      ram_req_o.addr   = req_i.addr & OFFS_MASK;
      reg_req_o.addr   = req_i.addr & OFFS_MASK;
      ram_req_o.avalid = req_i.avalid & ~hit_reg;
      reg_req_o.avalid = req_i.avalid & hit_reg;
   end

   // Handshake from the addressed target
   always_comb begin
      if (hit_reg) begin
         rsp_o.ready_nxt  = reg_rsp_i.ready_nxt;
         rsp_o.rvalid_nxt = reg_rsp_i.rvalid_nxt;
      end else begin
         rsp_o.ready_nxt  = ram_rsp_i.ready_nxt;
         rsp_o.rvalid_nxt = ram_rsp_i.rvalid_nxt;
      end
      rsp_o.rdata = sel_reg_q ? reg_rsp_i.rdata : ram_rsp_i.rdata;
   end

   // Data lags the handshake by one cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sel_reg_q <= 1'b0;
      end else if (req_i.avalid && rsp_o.ready_nxt) begin
         sel_reg_q <= hit_reg;
      end
   end

   // A waiting request keeps its target
   a_target_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      req_i.avalid && !rsp_o.ready_nxt |=> $stable(hit_reg)
   ) else $error("iob_split: target changed while a request was waiting");

endmodule

//--- design/iob_ram_sp.sv
`timescale 1ns/1ps

module iob_ram_sp #(
   parameter int MEM_ADDR_W = 8                // log2 of the depth in words
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t req_i,
   output apb_iob_pkg::iob_rsp_t rsp_o
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;

   apb_iob_pkg::data_t    mem [DEPTH];
   apb_iob_pkg::data_t    rdata_q;
   logic [MEM_ADDR_W-1:0] word_idx;
   logic                  is_read;

   // Byte address to word, upper bits wrap
   assign word_idx = req_i.addr[MEM_ADDR_W+1:2];
   assign is_read  = ~|req_i.wstrb;

   // Byte lanes written under their strobes
   always_ff @(posedge clk_i) begin
      if (req_i.avalid) begin
         for (int b = 0; b < apb_iob_pkg::STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else if (req_i.avalid && is_read) begin
         rdata_q <= mem[word_idx];                // One cycle read latency
      end
   end

   // No wait states
   always_comb begin
      rsp_o.ready_nxt  = req_i.avalid;
      rsp_o.rvalid_nxt = req_i.avalid & is_read;
      rsp_o.rdata      = rdata_q;
   end

endmodule

//--- design/iob_regbank.sv
`timescale 1ns/1ps

module iob_regbank #(
   parameter int WAIT_CYC = 1                   // Cycles of avalid before ready
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::iob_req_t req_i,
   output apb_iob_pkg::iob_rsp_t rsp_o
);

   localparam int CNT_W = (WAIT_CYC > 0) ? $clog2(WAIT_CYC + 1) : 1;
   localparam int IDX_W = apb_iob_pkg::REG_IDX_W;
   localparam logic [IDX_W-1:0] ID_IDX = IDX_W'(apb_iob_pkg::REG_ID_IDX);

   apb_iob_pkg::data_t regs_q [apb_iob_pkg::REG_ID_IDX];   // Writable words only
   apb_iob_pkg::data_t rdata_q;
   apb_iob_pkg::data_t rd_word;
   logic [CNT_W-1:0]   wait_cnt_q;
   logic [IDX_W-1:0]   reg_idx;
   logic               ready_nxt;
   logic               is_read;

   assign reg_idx   = req_i.addr[IDX_W+1:2];
   assign is_read   = ~|req_i.wstrb;
   assign ready_nxt = req_i.avalid && (wait_cnt_q == CNT_W'(WAIT_CYC));

   // Counts cycles of a pending request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wait_cnt_q <= '0;
      end else if (!req_i.avalid) begin
         wait_cnt_q <= '0;
      end else if (!ready_nxt) begin
         wait_cnt_q <= wait_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int r = 0; r < apb_iob_pkg::REG_ID_IDX; r++) begin
            regs_q[r] <= '0;
         end
      end else if (ready_nxt && reg_idx < ID_IDX) begin
         for (int b = 0; b < apb_iob_pkg::STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               regs_q[reg_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // ID word is a constant, writes to it fall away
   always_comb begin
      rd_word = apb_iob_pkg::REG_ID_VALUE;
      if (reg_idx != ID_IDX) begin
         rd_word = regs_q[reg_idx];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else if (ready_nxt && is_read) begin
         rdata_q <= rd_word;
      end
   end

   always_comb begin
      rsp_o.ready_nxt  = ready_nxt;
      rsp_o.rvalid_nxt = ready_nxt & is_read;
      rsp_o.rdata      = rdata_q;
   end

endmodule

//--- design/apb_iob_top.sv
`timescale 1ns/1ps

module apb_iob_top #(
   parameter int MEM_ADDR_W = 8,   // RAM of 256 words
   parameter int WAIT_CYC   = 1    // Register bank wait states
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_iob_pkg::apb_req_t apb_req_i,
   output apb_iob_pkg::apb_rsp_t apb_rsp_o
);

   apb_iob_pkg::iob_req_t bridge_req;   // Bridge to splitter
   apb_iob_pkg::iob_rsp_t bridge_rsp;
   apb_iob_pkg::iob_req_t ram_req;
   apb_iob_pkg::iob_rsp_t ram_rsp;
   apb_iob_pkg::iob_req_t reg_req;
   apb_iob_pkg::iob_rsp_t reg_rsp;

   apb2iob i_apb2iob (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req_i),
      .apb_rsp_o (apb_rsp_o),
      .iob_req_o (bridge_req),
      .iob_rsp_i (bridge_rsp)
   );

   iob_split i_split (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (bridge_req),
      .rsp_o     (bridge_rsp),
      .ram_req_o (ram_req),
      .ram_rsp_i (ram_rsp),
      .reg_req_o (reg_req),
      .reg_rsp_i (reg_rsp)
   );

   iob_ram_sp #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) i_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (ram_req),
      .rsp_o   (ram_rsp)
   );

   iob_regbank #(
      .WAIT_CYC (WAIT_CYC)
   ) i_regbank (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (reg_req),
      .rsp_o   (reg_rsp)
   );

endmodule

//--- tests/apb_iob_tb_tasks.svh
// One APB transfer, setup then access until ready
task automatic apb_xfer(input logic wr, input apb_iob_pkg::addr_t addr,
                        input apb_iob_pkg::data_t wdata, input apb_iob_pkg::strb_t strb,
                        output apb_iob_pkg::data_t rdata, output int waits);
   int cyc;
   cyc = 0;
   @(negedge clk_i);
   apb_req.sel    = 1'b1;                 // Setup phase
   apb_req.enable = 1'b0;
   apb_req.write  = wr;
   apb_req.addr   = addr;
   apb_req.wdata  = wr ? wdata : '0;
   apb_req.strb   = wr ? strb : '0;
   @(negedge clk_i);
   apb_req.enable = 1'b1;                 // Access phase
   while (!apb_rsp.ready && cyc < XFER_TIMEOUT) begin
      cyc++;
      @(negedge clk_i);
   end
   waits = cyc;
   rdata = apb_rsp.rdata;                 // Valid alongside ready
   if (!apb_rsp.ready) begin
      abort_run($sformatf("Timeout: no APB ready for address 0x%04h after %0d cycles",
                          addr, cyc));
   end else begin
      @(negedge clk_i);                   // Ready taken at the edge just passed
      apb_req.sel    = 1'b0;
      apb_req.enable = 1'b0;
   end
endtask

task automatic check_rdata(input apb_iob_pkg::data_t got, input apb_iob_pkg::data_t exp,
                           input int step);
   if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: step %0d read 0x%08h, expected 0x%08h",
                          $time, step, got, exp));
   end
endtask

task automatic check_wait(input int got, input int exp, input int step);
   if (got != exp) begin
      abort_run($sformatf("MISMATCH at %0t: step %0d took %0d wait cycles, expected %0d",
                          $time, step, got, exp));
   end
endtask

//--- tests/apb_iob_tb.sv
`timescale 1ns/1ps

module apb_iob_tb;

   localparam int MEM_ADDR_W    = 8;
   localparam int WAIT_CYC      = 1;
   localparam int RAM_WORDS     = 2 ** MEM_ADDR_W;
   localparam int REG_WORDS     = 4;
   localparam int XFER_TIMEOUT  = 50;     // Access cycles before giving up
   localparam int SEED          = 99500;

   // One table row
   typedef struct packed {
      logic               wr;
      apb_iob_pkg::addr_t addr;
      apb_iob_pkg::data_t wdata;          // Zero on a write means random data
      apb_iob_pkg::strb_t strb;
      int                 exp_wait;       // Access cycles with ready low
   } step_t;

   logic                  clk_i;
   logic                  rst_n_i;
   apb_iob_pkg::apb_req_t apb_req;
   apb_iob_pkg::apb_rsp_t apb_rsp;

   step_t                 steps [$];
   apb_iob_pkg::data_t    shadow_ram  [RAM_WORDS];
   apb_iob_pkg::data_t    shadow_regs [REG_WORDS];

   apb_iob_top #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .WAIT_CYC   (WAIT_CYC)
   ) i_dut (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   `include "apb_iob_tb_tasks.svh"

   // Keeps old bytes where the strobe is clear
   function automatic apb_iob_pkg::data_t byte_merge(input apb_iob_pkg::data_t old_w,
                                                     input apb_iob_pkg::data_t new_w,
                                                     input apb_iob_pkg::strb_t strb);
      apb_iob_pkg::data_t mask;
      for (int b = 0; b < apb_iob_pkg::STRB_W; b++) begin
         mask[8*b +: 8] = {8{strb[b]}};
      end
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   function automatic void model_write(input apb_iob_pkg::addr_t addr,
                                       input apb_iob_pkg::data_t wdata,
                                       input apb_iob_pkg::strb_t strb);
      int idx;
      if (addr[apb_iob_pkg::SPLIT_BIT]) begin
         idx = (int'(addr) >> 2) % REG_WORDS;
         if (idx != apb_iob_pkg::REG_ID_IDX) begin   // ID word is read-only
            shadow_regs[idx] = byte_merge(shadow_regs[idx], wdata, strb);
         end
      end else begin
         idx = (int'(addr) >> 2) % RAM_WORDS;        // Wraps modulo the depth
         shadow_ram[idx] = byte_merge(shadow_ram[idx], wdata, strb);
      end
   endfunction

   function automatic apb_iob_pkg::data_t model_read(input apb_iob_pkg::addr_t addr);
      int idx;
      if (addr[apb_iob_pkg::SPLIT_BIT]) begin
         idx = (int'(addr) >> 2) % REG_WORDS;
         if (idx == apb_iob_pkg::REG_ID_IDX) begin
            return apb_iob_pkg::REG_ID_VALUE;
         end
         return shadow_regs[idx];
      end
      idx = (int'(addr) >> 2) % RAM_WORDS;
      return shadow_ram[idx];
   endfunction

   function automatic void add_step(input logic wr, input apb_iob_pkg::addr_t addr,
                                    input apb_iob_pkg::data_t wdata,
                                    input apb_iob_pkg::strb_t strb, input int exp_wait);
      step_t s;
      s.wr       = wr;
      s.addr     = addr;
      s.wdata    = wdata;
      s.strb     = strb;
      s.exp_wait = exp_wait;
      steps.push_back(s);
   endfunction

   function automatic void build_table();
      add_step(1'b0, 16'h1000, 32'h0, 4'h0, 2);          // Registers clear after reset
      add_step(1'b0, 16'h1004, 32'h0, 4'h0, 2);
      add_step(1'b0, 16'h1008, 32'h0, 4'h0, 2);
      add_step(1'b1, 16'h0000, 32'h0, 4'hF, 1);          // RAM full words
      add_step(1'b1, 16'h0004, 32'h0, 4'hF, 1);
      add_step(1'b1, 16'h0010, 32'h0, 4'hF, 1);
      add_step(1'b1, 16'h03FC, 32'hCAFE_F00D, 4'hF, 1);
      add_step(1'b0, 16'h0000, 32'h0, 4'h0, 1);
      add_step(1'b0, 16'h0004, 32'h0, 4'h0, 1);
      add_step(1'b0, 16'h0010, 32'h0, 4'h0, 1);
      add_step(1'b0, 16'h03FC, 32'h0, 4'h0, 1);
      add_step(1'b1, 16'h0004, 32'h0, 4'b0101, 1);       // RAM partial strobes
      add_step(1'b0, 16'h0004, 32'h0, 4'h0, 1);
      add_step(1'b1, 16'h0010, 32'hDEAD_BEEF, 4'b1000, 1);
      add_step(1'b0, 16'h0010, 32'h0, 4'h0, 1);
      add_step(1'b1, 16'h03FC, 32'h0, 4'b0110, 1);
      add_step(1'b0, 16'h03FC, 32'h0, 4'h0, 1);
      add_step(1'b1, 16'h1000, 32'h0, 4'hF, 2);          // Control registers
      add_step(1'b1, 16'h1004, 32'h0, 4'hF, 2);
      add_step(1'b1, 16'h1008, 32'h5A5A_0FF0, 4'hF, 2);
      add_step(1'b0, 16'h1000, 32'h0, 4'h0, 2);
      add_step(1'b0, 16'h1004, 32'h0, 4'h0, 2);
      add_step(1'b0, 16'h1008, 32'h0, 4'h0, 2);
      add_step(1'b1, 16'h1004, 32'h0, 4'b0011, 2);
      add_step(1'b0, 16'h1004, 32'h0, 4'h0, 2);
      add_step(1'b1, 16'h1008, 32'h0, 4'b1100, 2);
      add_step(1'b0, 16'h1008, 32'h0, 4'h0, 2);
      add_step(1'b1, 16'h100C, 32'h1234_5678, 4'hF, 2);  // ID word ignores writes
      add_step(1'b0, 16'h100C, 32'h0, 4'h0, 2);
      add_step(1'b0, 16'h1000, 32'h0, 4'h0, 2);
      add_step(1'b1, 16'h0400, 32'h0, 4'hF, 1);          // Wraps onto word 0
      add_step(1'b0, 16'h0000, 32'h0, 4'h0, 1);
      add_step(1'b0, 16'h0804, 32'h0, 4'h0, 1);
      add_step(1'b0, 16'h0C10, 32'h0, 4'h0, 1);
      add_step(1'b1, 16'h0FFC, 32'h0, 4'hF, 1);          // Top word lands on 0x3FC
      add_step(1'b0, 16'h03FC, 32'h0, 4'h0, 1);
   endfunction

   initial begin
      step_t              s;
      apb_iob_pkg::data_t wd;
      apb_iob_pkg::data_t got;
      int                 waits;
      void'($urandom(SEED));
      rst_n_i = 1'b0;
      apb_req = '0;
      for (int r = 0; r < REG_WORDS; r++) begin
         shadow_regs[r] = '0;
      end
      build_table();
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      foreach (steps[i]) begin
         s  = steps[i];
         wd = s.wdata;
         if (s.wr && wd == '0) begin
            wd = $urandom();
         end
         apb_xfer(s.wr, s.addr, wd, s.strb, got, waits);
         check_wait(waits, s.exp_wait, i);
         if (s.wr) begin
            model_write(s.addr, wd, s.strb);
         end else begin
            check_rdata(got, model_read(s.addr), i);
         end
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- flist.f
+incdir+tests
design/apb_iob_pkg.sv
design/apb2iob.sv
design/iob_split.sv
design/iob_ram_sp.sv
design/iob_regbank.sv
design/apb_iob_top.sv
tests/apb_iob_tb.sv

//--- Makefile
SRCS := $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vapb_iob_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module apb_iob_tb -f flist.f

run: obj_dir/Vapb_iob_tb
	./obj_dir/Vapb_iob_tb | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
